//--- branch_controller.sv
module branch_controller (
    input  logic                                  clk,
    input  logic                                  arst_n,

    input  lc3b_types::lc3b_word                  stage_if_ir,
    input  lc3b_types::lc3b_word                  stage_if_pc,
    input  logic                                  stage_if_valid,
    input  logic                                  branch_prediction,
    input  lc3b_types::lc3b_bht_index             bht_index,

    input  lc3b_types::lc3b_word                  ex_mem_alu,
    input  lc3b_types::lc3b_word                  ex_mem_pcn,
    input  lc3b_types::lc3b_control_word          ex_mem_control,
    input  lc3b_types::lc3b_opcode                ex_mem_opcode,
    input  logic                                  ex_mem_valid,
    input  logic                                  stage_mem_br_en,

    input  lc3b_types::lc3b_word                  mem_wb_mdr,
    input  lc3b_types::lc3b_control_word          mem_wb_control,
    input  lc3b_types::lc3b_opcode                mem_wb_opcode,
    input  logic                                  mem_wb_valid,

    input  lc3b_types::lc3b_branch_record         head_record,
    input  logic                                  queue_empty,

    output lc3b_types::lc3b_word                  pc_out,
    output lc3b_types::lc3b_word                  pc_plus2_out,
    output lc3b_types::lc3b_pipeline_control_word pipeline_control_request,
    output logic                                  push,
    output lc3b_types::lc3b_branch_record         push_record,
    output logic                                  pop,
    output logic                                  flush,
    output logic                                  train,
    output lc3b_types::lc3b_bht_index             train_index,
    output logic                                  train_taken,
    output logic                                  prediction_correct,
    output logic                                  prediction_incorrect
);

    lc3b_types::lc3b_word       branch_address;
    lc3b_types::lc3b_opcode     stage_if_opcode;
    lc3b_types::lc3b_pc_mux_sel pc_mux_sel;
    logic                       if_br;
    logic                       ex_mem_br;

    assign stage_if_opcode = lc3b_types::lc3b_opcode'(stage_if_ir[15:12]);
    assign pc_plus2_out    = stage_if_pc + 16'd2;

    // PCoffset9 is a word offset.
    assign branch_address = pc_plus2_out + {{6{stage_if_ir[8]}}, stage_if_ir[8:0], 1'b0};

    assign if_br     = stage_if_valid && stage_if_opcode == lc3b_types::op_br;
    assign ex_mem_br = ex_mem_valid && ex_mem_opcode == lc3b_types::op_br;

    // the record keeps whichever address fetch did not take.
    assign push_record.prediction         = branch_prediction;
    assign push_record.bht_index          = bht_index;
    assign push_record.mispredict_address = branch_prediction ? pc_plus2_out : branch_address;

    assign pop         = ex_mem_br;
    assign train       = ex_mem_br;
    assign train_index = head_record.bht_index;
    assign train_taken = stage_mem_br_en;

    // a discarded fetch must not leave a record behind.
    assign push = if_br && !flush;

    always_comb begin
        pipeline_control_request = '0;
        prediction_correct       = 1'b0;
        prediction_incorrect     = 1'b0;
        flush                    = 1'b0;
        pc_mux_sel               = lc3b_types::lc3b_pc_mux_sel_pc_plus2;

        if (if_br && branch_prediction) begin
            pc_mux_sel = lc3b_types::lc3b_pc_mux_sel_branch_address;
        end

        if (ex_mem_br) begin
            if (head_record.prediction == stage_mem_br_en) begin
                prediction_correct = 1'b1;
                pc_mux_sel         = lc3b_types::lc3b_pc_mux_sel_pc_plus2;
            end else begin
                prediction_incorrect = 1'b1;
                flush                = 1'b1;
                pc_mux_sel           = lc3b_types::lc3b_pc_mux_sel_mispredict_address;
                pipeline_control_request.active               = 1'b1;
                pipeline_control_request.barrier_if_id_reset  = 1'b1;
                pipeline_control_request.barrier_id_ex_reset  = 1'b1;
                pipeline_control_request.barrier_ex_mem_reset = 1'b1;
            end
        end

        if (ex_mem_valid && (ex_mem_opcode == lc3b_types::op_jmp ||
                             ex_mem_opcode == lc3b_types::op_jsr)) begin
            flush      = 1'b1;
            pc_mux_sel = ex_mem_control.pc_mux_sel; // alu for jmp, pcn for jsr.
            pipeline_control_request.active               = 1'b1;
            pipeline_control_request.barrier_if_id_reset  = 1'b1;
            pipeline_control_request.barrier_id_ex_reset  = 1'b1;
            pipeline_control_request.barrier_ex_mem_reset = 1'b1;
        end

        // the trap vector is not known until MEM_WB, so only squash here.
        if (ex_mem_valid && ex_mem_opcode == lc3b_types::op_trap) begin
            flush = 1'b1;
            pipeline_control_request.active               = 1'b1;
            pipeline_control_request.barrier_if_id_reset  = 1'b1;
            pipeline_control_request.barrier_id_ex_reset  = 1'b1;
            pipeline_control_request.barrier_ex_mem_reset = 1'b1;
        end

        if (mem_wb_valid && mem_wb_opcode == lc3b_types::op_trap) begin
            flush      = 1'b1;
            pc_mux_sel = mem_wb_control.pc_mux_sel;
            pipeline_control_request.active               = 1'b1;
            pipeline_control_request.barrier_if_id_reset  = 1'b1;
            pipeline_control_request.barrier_id_ex_reset  = 1'b1;
            pipeline_control_request.barrier_ex_mem_reset = 1'b1;
            pipeline_control_request.barrier_mem_wb_reset = 1'b1;
        end
    end

    always_comb begin
        case (pc_mux_sel)
            lc3b_types::lc3b_pc_mux_sel_alu:                pc_out = ex_mem_alu;
            lc3b_types::lc3b_pc_mux_sel_pcn:                pc_out = ex_mem_pcn;
            lc3b_types::lc3b_pc_mux_sel_mdr:                pc_out = mem_wb_mdr;
            lc3b_types::lc3b_pc_mux_sel_branch_address:     pc_out = branch_address;
            lc3b_types::lc3b_pc_mux_sel_mispredict_address: pc_out = head_record.mispredict_address;
            default:                                        pc_out = pc_plus2_out;
        endcase
    end

    // a resolution is either a hit or a miss, never both.
    one_prediction_strobe: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(prediction_correct && prediction_incorrect)
    ) else $error("both prediction strobes high");

    // control words from decode must name one of the six sources.
    legal_pc_mux_sel: assert property (
        @(posedge clk) disable iff (!arst_n)
        pc_mux_sel inside {lc3b_types::lc3b_pc_mux_sel_pc_plus2,
                           lc3b_types::lc3b_pc_mux_sel_alu,
                           lc3b_types::lc3b_pc_mux_sel_pcn,
                           lc3b_types::lc3b_pc_mux_sel_mdr,
                           lc3b_types::lc3b_pc_mux_sel_branch_address,
                           lc3b_types::lc3b_pc_mux_sel_mispredict_address}
    ) else $error("illegal next-PC select");

    // a br in EX_MEM resolves against the queue, so a record must be waiting.
    resolve_has_record: assert property (
        @(posedge clk) disable iff (!arst_n)
        ex_mem_br |-> !queue_empty
    ) else $error("br resolved with no queued prediction");

endmodule : branch_controller

//--- branch_predictor.sv
`include "lc3b_branch_params.svh"

module branch_predictor (
    input  logic                      clk,
    input  logic                      arst_n,
    input  lc3b_types::lc3b_word      read_pc,
    input  logic                      train,
    input  lc3b_types::lc3b_bht_index train_index,
    input  logic                      train_taken,
    output logic                      prediction,
    output lc3b_types::lc3b_bht_index read_index
);

    lc3b_types::lc3b_bht_counter counters [`LC3B_BHT_ENTRIES];
    lc3b_types::lc3b_bht_counter train_ctr;

    // instructions are word aligned, so bit 0 carries no information.
    assign read_index = read_pc[`LC3B_BHT_INDEX_W:1];

    // taken when the counter sits in one of the two upper states.
    assign prediction = counters[read_index][1];

    assign train_ctr = counters[train_index];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LC3B_BHT_ENTRIES; i++) begin
                counters[i] <= `LC3B_CTR_RESET;
            end
        end else if (train) begin
            if (train_taken) begin
                if (train_ctr != 2'd3) begin
                    counters[train_index] <= train_ctr + 2'd1;
                end
            end else begin
                if (train_ctr != 2'd0) begin
                    counters[train_index] <= train_ctr - 2'd1;
                end
            end
        end
    end

endmodule : branch_predictor

//--- branch_unit.f
+incdir+.
lc3b_types.sv
branch_predictor.sv
branch_waterfall_queue.sv
branch_controller.sv
branch_unit.sv
branch_unit_tb.sv

//--- branch_unit.sv
module branch_unit (
    input  logic                                  clk,
    input  logic                                  arst_n,

    input  lc3b_types::lc3b_word                  stage_if_ir,
    input  lc3b_types::lc3b_word                  stage_if_pc,
    input  logic                                  stage_if_valid,

    input  lc3b_types::lc3b_word                  ex_mem_alu,
    input  lc3b_types::lc3b_word                  ex_mem_pcn,
    input  lc3b_types::lc3b_control_word          ex_mem_control,
    input  lc3b_types::lc3b_opcode                ex_mem_opcode,
    input  logic                                  ex_mem_valid,
    input  logic                                  stage_mem_br_en,

    input  lc3b_types::lc3b_word                  mem_wb_mdr,
    input  lc3b_types::lc3b_control_word          mem_wb_control,
    input  lc3b_types::lc3b_opcode                mem_wb_opcode,
    input  logic                                  mem_wb_valid,

    output lc3b_types::lc3b_word                  pc_out,
    output lc3b_types::lc3b_word                  pc_plus2_out,
    output lc3b_types::lc3b_pipeline_control_word pipeline_control_request,
    output logic                                  prediction_correct,
    output logic                                  prediction_incorrect
);

    logic                          branch_prediction;
    lc3b_types::lc3b_bht_index     bht_index;
    logic                          push;
    lc3b_types::lc3b_branch_record push_record;
    logic                          pop;
    logic                          flush;
    lc3b_types::lc3b_branch_record head_record;
    logic                          queue_empty;
    logic                          train;
    lc3b_types::lc3b_bht_index     train_index;
    logic                          train_taken;

    branch_predictor bht_i (
        .clk,
        .arst_n,
        .read_pc     (stage_if_pc),
        .train,
        .train_index,
        .train_taken,
        .prediction  (branch_prediction),
        .read_index  (bht_index)
    );

    branch_waterfall_queue brq_i (
        .clk,
        .arst_n,
        .push,
        .push_record,
        .pop,
        .flush,
        .head_record,
        .empty       (queue_empty)
    );

    branch_controller ctrl_i (
        .clk,
        .arst_n,
        .stage_if_ir,
        .stage_if_pc,
        .stage_if_valid,
        .branch_prediction,
        .bht_index,
        .ex_mem_alu,
        .ex_mem_pcn,
        .ex_mem_control,
        .ex_mem_opcode,
        .ex_mem_valid,
        .stage_mem_br_en,
        .mem_wb_mdr,
        .mem_wb_control,
        .mem_wb_opcode,
        .mem_wb_valid,
        .head_record,
        .queue_empty,
        .pc_out,
        .pc_plus2_out,
        .pipeline_control_request,
        .push,
        .push_record,
        .pop,
        .flush,
        .train,
        .train_index,
        .train_taken,
        .prediction_correct,
        .prediction_incorrect
    );

endmodule : branch_unit

//--- branch_unit_tb.sv
module branch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic arst_n;
    logic stage_if_valid;
    logic ex_mem_valid;
    logic mem_wb_valid;
    logic stage_mem_br_en;
    logic prediction_correct;
    logic prediction_incorrect;
    lc3b_types::lc3b_word stage_if_ir;
    lc3b_types::lc3b_word stage_if_pc;
    lc3b_types::lc3b_word ex_mem_alu;
    lc3b_types::lc3b_word ex_mem_pcn;
    lc3b_types::lc3b_word mem_wb_mdr;
    lc3b_types::lc3b_word pc_out;
    lc3b_types::lc3b_word pc_plus2_out;
    lc3b_types::lc3b_control_word ex_mem_control;
    lc3b_types::lc3b_control_word mem_wb_control;
    lc3b_types::lc3b_opcode ex_mem_opcode;
    lc3b_types::lc3b_opcode mem_wb_opcode;
    lc3b_types::lc3b_pipeline_control_word pipeline_control_request;

    lc3b_types::lc3b_branch_record expected_q [$]; // records the DUT should hold, oldest first.
    logic [31:0] lcg_state = 32'd51273;
    int error_count = 0;

    branch_unit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic lc3b_types::lc3b_word next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // random upper PC bits around a chosen table index.
    function automatic lc3b_types::lc3b_word pc_at_index(logic [3:0] index);
        lc3b_types::lc3b_word r;
        r = next_rand();
        return {r[15:5], index, 1'b0};
    endfunction

    function automatic lc3b_types::lc3b_word br_target(lc3b_types::lc3b_word pc,
                                                       logic [8:0] offset);
        int disp;
        disp = 2 * int'($signed(offset));
        return lc3b_types::lc3b_word'(int'(pc) + 2 + disp);
    endfunction

    function automatic lc3b_types::lc3b_pipeline_control_word squash_request(logic with_mem_wb);
        lc3b_types::lc3b_pipeline_control_word w;
        w = '0;
        w.active = 1'b1;
        w.barrier_if_id_reset = 1'b1;
        w.barrier_id_ex_reset = 1'b1;
        w.barrier_ex_mem_reset = 1'b1;
        w.barrier_mem_wb_reset = with_mem_wb;
        return w;
    endfunction

    task automatic check_word(lc3b_types::lc3b_word got, lc3b_types::lc3b_word exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_request(lc3b_types::lc3b_pipeline_control_word got,
                                 lc3b_types::lc3b_pipeline_control_word exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    // every cycle starts with all stages empty.
    task automatic next_cycle();
        @(posedge clk);
        stage_if_valid <= 1'b0;
        ex_mem_valid <= 1'b0;
        mem_wb_valid <= 1'b0;
        stage_mem_br_en <= 1'b0;
    endtask

    task automatic check_outputs(lc3b_types::lc3b_word exp_pc,
                                 lc3b_types::lc3b_pipeline_control_word exp_req,
                                 logic exp_correct, logic exp_incorrect);
        @(negedge clk); // outputs are settled halfway through the cycle.
        check_word(pc_out, exp_pc, "pc_out");
        check_request(pipeline_control_request, exp_req, "pipeline_control_request");
        check_bit(prediction_correct, exp_correct, "prediction_correct");
        check_bit(prediction_incorrect, exp_incorrect, "prediction_incorrect");
    endtask

    task automatic drive_if_br(lc3b_types::lc3b_word pc, logic [8:0] offset);
        stage_if_valid <= 1'b1;
        stage_if_pc <= pc;
        stage_if_ir <= {4'b0000, 3'b111, offset};
    endtask

    task automatic fetch_branch(logic [3:0] index, logic predict_taken);
        lc3b_types::lc3b_word pc;
        lc3b_types::lc3b_word r;
        logic [8:0] offset;
        lc3b_types::lc3b_branch_record rec;
        pc = pc_at_index(index);
        r = next_rand();
        offset = r[8:0];
        rec.prediction = predict_taken;
        rec.bht_index = index;
        rec.mispredict_address = predict_taken ? pc + 16'd2 : br_target(pc, offset);
        next_cycle();
        drive_if_br(pc, offset);
        check_outputs(predict_taken ? br_target(pc, offset) : pc + 16'd2, '0, 1'b0, 1'b0);
        check_word(pc_plus2_out, pc + 16'd2, "pc_plus2_out");
        expected_q.push_back(rec);
    endtask

    task automatic resolve_branch(logic taken);
        lc3b_types::lc3b_branch_record head;
        head = expected_q.pop_front();
        next_cycle();
        ex_mem_valid <= 1'b1;
        ex_mem_opcode <= lc3b_types::op_br;
        stage_mem_br_en <= taken;
        if (head.prediction == taken) begin
            check_outputs(stage_if_pc + 16'd2, '0, 1'b1, 1'b0);
        end else begin
            check_outputs(head.mispredict_address, squash_request(1'b0), 1'b0, 1'b1);
            expected_q.delete(); // younger records are flushed with the wrong path.
        end
    endtask

    // the first taken outcome moves the counter from weakly not taken to weakly taken.
    task automatic train_predictor();
        fetch_branch(4'd3, 1'b0);
        resolve_branch(1'b1);
        fetch_branch(4'd3, 1'b1);
        resolve_branch(1'b1);
        fetch_branch(4'd3, 1'b1);
        fetch_branch(4'd9, 1'b0);
        resolve_branch(1'b1);
        resolve_branch(1'b0);
    endtask

    task automatic resolve_in_order();
        fetch_branch(4'd5, 1'b0);
        fetch_branch(4'd12, 1'b0);
        resolve_branch(1'b0);
        resolve_branch(1'b1);
    endtask

    task automatic redirect_on_jumps();
        lc3b_types::lc3b_word target;
        target = next_rand();
        next_cycle();
        drive_if_br(pc_at_index(4'd6), 9'h1f0);
        ex_mem_valid <= 1'b1;
        ex_mem_opcode <= lc3b_types::op_jmp;
        ex_mem_control.pc_mux_sel <= lc3b_types::lc3b_pc_mux_sel_alu;
        ex_mem_alu <= target;
        ex_mem_pcn <= ~target;
        check_outputs(target, squash_request(1'b0), 1'b0, 1'b0);
        next_cycle();
        drive_if_br(pc_at_index(4'd6), 9'h1f0);
        ex_mem_valid <= 1'b1;
        ex_mem_opcode <= lc3b_types::op_jsr;
        ex_mem_control.pc_mux_sel <= lc3b_types::lc3b_pc_mux_sel_pcn;
        check_outputs(~target, squash_request(1'b0), 1'b0, 1'b0);
        fetch_branch(4'd7, 1'b0); // must be the head when it resolves.
        resolve_branch(1'b1);
    endtask

    task automatic trap_over_mispredict();
        lc3b_types::lc3b_word vector;
        vector = next_rand();
        fetch_branch(4'd10, 1'b0);
        expected_q.delete();
        next_cycle();
        ex_mem_valid <= 1'b1;
        ex_mem_opcode <= lc3b_types::op_br;
        stage_mem_br_en <= 1'b1;
        mem_wb_valid <= 1'b1;
        mem_wb_opcode <= lc3b_types::op_trap;
        mem_wb_control.pc_mux_sel <= lc3b_types::lc3b_pc_mux_sel_mdr;
        mem_wb_mdr <= vector;
        check_outputs(vector, squash_request(1'b1), 1'b0, 1'b1);
    endtask

    task automatic squash_on_ex_mem_trap();
        lc3b_types::lc3b_word pc;
        pc = pc_at_index(4'd1);
        next_cycle();
        stage_if_valid <= 1'b1;
        stage_if_pc <= pc;
        stage_if_ir <= {lc3b_types::op_add, 12'h042};
        ex_mem_valid <= 1'b1;
        ex_mem_opcode <= lc3b_types::op_trap;
        check_outputs(pc + 16'd2, squash_request(1'b0), 1'b0, 1'b0);
    endtask

    initial begin
        int idle_wait;
        arst_n <= 1'b0;
        stage_if_ir <= '0;
        stage_if_pc <= '0;
        stage_if_valid <= 1'b0;
        ex_mem_alu <= '0;
        ex_mem_pcn <= '0;
        ex_mem_control <= '0;
        ex_mem_opcode <= lc3b_types::op_add;
        ex_mem_valid <= 1'b0;
        stage_mem_br_en <= 1'b0;
        mem_wb_mdr <= '0;
        mem_wb_control <= '0;
        mem_wb_opcode <= lc3b_types::op_add;
        mem_wb_valid <= 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        idle_wait = 0;
        do begin
            @(negedge clk);
            idle_wait++;
            if (idle_wait > 20) begin
                $display("timed out waiting for the branch unit to go idle after reset");
                $display("Test failed");
                $finish;
            end
        end while (pipeline_control_request !== '0 || prediction_correct !== 1'b0 ||
                   prediction_incorrect !== 1'b0);
        train_predictor();
        resolve_in_order();
        redirect_on_jumps();
        trap_over_mispredict();
        squash_on_ex_mem_trap();
        next_cycle();
        @(negedge clk);
        $display("checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : branch_unit_tb

//--- branch_waterfall_queue.sv
`include "lc3b_branch_params.svh"

module branch_waterfall_queue (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          push,
    input  lc3b_types::lc3b_branch_record push_record,
    input  logic                          pop,
    input  logic                          flush,
    output lc3b_types::lc3b_branch_record head_record,
    output logic                          empty
);

    localparam int CNT_W  = $clog2(`LC3B_BRQ_DEPTH + 1);
    localparam int SLOT_W = $clog2(`LC3B_BRQ_DEPTH);

    lc3b_types::lc3b_branch_record entries [`LC3B_BRQ_DEPTH];

    logic [CNT_W-1:0]  count;
    logic [SLOT_W-1:0] wr_slot;
    logic              full;
    logic              do_push;

    assign empty       = (count == '0);
    assign full        = (count == CNT_W'(`LC3B_BRQ_DEPTH));
    assign head_record = entries[0];

    // a flushed cycle discards whatever is being fetched.
    assign do_push = push && !flush;

    // when the head leaves in the same cycle, the new record lands one slot lower.
    assign wr_slot = SLOT_W'(count - CNT_W'(pop));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(do_push) - CNT_W'(pop);
        end
    end

    // older records fall toward the head as branches resolve.
    always_ff @(posedge clk) begin
        if (pop) begin
            for (int i = 0; i < `LC3B_BRQ_DEPTH - 1; i++) begin
                entries[i] <= entries[i+1];
            end
        end
        if (do_push) begin
            entries[wr_slot] <= push_record; // wins over the shift at the same slot.
        end
    end

    // IF cannot run more branches ahead than the queue holds.
    no_push_when_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        do_push && full |-> pop
    ) else $error("branch queue overflow");

    // every br reaching EX_MEM must have been recorded at fetch.
    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> !empty
    ) else $error("branch queue underflow");

endmodule : branch_waterfall_queue

//--- lc3b_branch_params.svh
`ifndef LC3B_BRANCH_PARAMS_SVH
`define LC3B_BRANCH_PARAMS_SVH

// Branches in flight between IF and EX_MEM never exceed this.
`define LC3B_BRQ_DEPTH 4

// Number of 2-bit counters in the branch history table.
`define LC3B_BHT_ENTRIES 16

// The table index comes from PC bits 4 down to 1.
`define LC3B_BHT_INDEX_W 4

// Counters come out of reset weakly not taken.
`define LC3B_CTR_RESET 2'd1

`endif

//--- lc3b_types.sv
`include "lc3b_branch_params.svh"

package lc3b_types;

    typedef logic [15:0] lc3b_word;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        lc3b_pc_mux_sel_pc_plus2           = 3'd0,
        lc3b_pc_mux_sel_alu                = 3'd1,
        lc3b_pc_mux_sel_pcn                = 3'd2,
        lc3b_pc_mux_sel_mdr                = 3'd3,
        lc3b_pc_mux_sel_branch_address     = 3'd4,
        lc3b_pc_mux_sel_mispredict_address = 3'd5
    } lc3b_pc_mux_sel;

    typedef struct packed {
        lc3b_pc_mux_sel pc_mux_sel;
    } lc3b_control_word;

    typedef struct packed {
        logic active;
        logic exclusive;
        logic barrier_if_id_stall;
        logic barrier_id_ex_stall;
        logic barrier_ex_mem_stall;
        logic barrier_mem_wb_stall;
        logic barrier_if_id_reset;
        logic barrier_id_ex_reset;
        logic barrier_ex_mem_reset;
        logic barrier_mem_wb_reset;
        logic barrier_id_ex_force_sr1_load;
        logic barrier_id_ex_force_sr2_load;
        logic stage_if_stall;
        logic stage_id_stall;
        logic stage_ex_stall;
        logic stage_mem_stall;
        logic stage_wb_stall;
    } lc3b_pipeline_control_word;

    typedef logic [`LC3B_BHT_INDEX_W-1:0] lc3b_bht_index;
    typedef logic [1:0]                   lc3b_bht_counter;

    // each predicted br leaves one 21-bit record.
    typedef struct packed {
        lc3b_word      mispredict_address;
        logic          prediction;
        lc3b_bht_index bht_index;
    } lc3b_branch_record;

endpackage : lc3b_types

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module branch_unit_tb -f branch_unit.f -o branch_unit_sim

./obj_dir/branch_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
